/* sim.f */
+incdir+hw
hw/core_pkg.sv
hw/issue_stage.sv
hw/exec_unit.sv
hw/reorder_buffer.sv
hw/retire_unit.sv
hw/ooo_core.sv
tests/ooo_core_tb.sv

/* Makefile */
# Verilator build and run for the ooo core slice

VERILATOR  ?= verilator
TOP        ?= ooo_core_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/ooo_core_tb.sv */
//////////////////////////////////////////////////
// ooo core slice testbench
// table-driven instruction stream with random
// idle gaps, in-order commit checker and timeout
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module ooo_core_tb;

	localparam int ROWS = 27;
	// worst case per row is a multiply plus pipeline slack
	localparam int CYCLE_LIMIT = ROWS * (`CORE_MUL_STAGES + 6) + 50;
	localparam logic [15:0] LFSR_SEED = 16'd2782;

	logic                     clock;
	logic                     reset;
	logic                     inst_valid;
	core_pkg::inst_packet_t   inst;
	logic                     inst_ready;
	core_pkg::commit_packet_t commit;

	// stimulus table and expected commits
	core_pkg::inst_packet_t   row_inst   [ROWS];
	core_pkg::commit_packet_t row_commit [ROWS];
	logic                     row_burst  [ROWS];
	int                       row_fill;

	int          commit_count;
	int          cycle_count;
	logic [15:0] lfsr;

	ooo_core ooo_core_i (
		.clock      (clock),
		.reset      (reset),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_ready (inst_ready),
		.commit     (commit)
	);

	initial begin
		clock = 1'b0;
	end

	always #5 clock = ~clock;

	////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////

	// galois lfsr, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			lfsr_next = (state >> 1) ^ 16'hB400;
		end else begin
			lfsr_next = state >> 1;
		end
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped on failure");
	endtask

	task automatic compare_commit(input string name, input core_pkg::commit_packet_t got,
			input core_pkg::commit_packet_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure("commit packet mismatch");
		end
	endtask

	task automatic compare_reg_idx(input string name, input core_pkg::reg_idx_t got,
			input core_pkg::reg_idx_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure("commit destination mismatch");
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure("control flag mismatch");
		end
	endtask

	// one table row, expected dest is always the instruction dest
	task automatic add_row(input core_pkg::alu_func_e func, input core_pkg::reg_idx_t dest,
			input core_pkg::reg_idx_t src1, input core_pkg::reg_idx_t src2,
			input logic use_imm, input core_pkg::xlen_t imm,
			input core_pkg::xlen_t value, input logic burst);
		row_inst[row_fill].func    = func;
		row_inst[row_fill].dest    = dest;
		row_inst[row_fill].src1    = src1;
		row_inst[row_fill].src2    = src2;
		row_inst[row_fill].use_imm = use_imm;
		row_inst[row_fill].imm     = imm;
		row_commit[row_fill].valid = 1'b1;
		row_commit[row_fill].dest  = dest;
		row_commit[row_fill].value = value;
		row_burst[row_fill]        = burst;
		row_fill                   = row_fill + 1;
	endtask

	////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////

	task automatic build_table();
		row_fill = 0;
		// immediate loads
		add_row(core_pkg::ADD, 5'd1, 5'd0, 5'd31, 1'b1, 32'h0000_0005, 32'h0000_0005, 1'b0);
		add_row(core_pkg::ADD, 5'd2, 5'd0, 5'd31, 1'b1, 32'h0000_0007, 32'h0000_0007, 1'b0);
		add_row(core_pkg::ADD, 5'd3, 5'd0, 5'd31, 1'b1, 32'h0000_00F0, 32'h0000_00F0, 1'b0);
		// alu operations, sub wraps below zero
		add_row(core_pkg::ADD, 5'd4, 5'd1, 5'd2, 1'b0, 32'h0, 32'h0000_000C, 1'b0);
		add_row(core_pkg::SUB, 5'd5, 5'd1, 5'd2, 1'b0, 32'h0, 32'hFFFF_FFFE, 1'b0);
		add_row(core_pkg::AND, 5'd6, 5'd3, 5'd2, 1'b1, 32'h0000_003C, 32'h0000_0030, 1'b0);
		add_row(core_pkg::XOR, 5'd7, 5'd3, 5'd2, 1'b0, 32'h0, 32'h0000_00F7, 1'b0);
		add_row(core_pkg::SLL, 5'd8, 5'd1, 5'd0, 1'b1, 32'h0000_0004, 32'h0000_0050, 1'b0);
		// shift amount uses only the low 5 bits
		add_row(core_pkg::SLL, 5'd9, 5'd2, 5'd0, 1'b1, 32'h0000_0023, 32'h0000_0038, 1'b0);
		// multiply, then younger alu ops that finish first
		// sent without gaps so the product is still in flight
		add_row(core_pkg::MUL, 5'd10, 5'd4, 5'd2, 1'b0, 32'h0, 32'h0000_0054, 1'b0);
		// src2 names the pending r10, ignored with use_imm
		add_row(core_pkg::ADD, 5'd11, 5'd1, 5'd10, 1'b1, 32'h0000_0001, 32'h0000_0006, 1'b1);
		add_row(core_pkg::XOR, 5'd12, 5'd2, 5'd0, 1'b1, 32'h0000_00FF, 32'h0000_00F8, 1'b1);
		// reads r10 while the multiply is still pending
		add_row(core_pkg::ADD, 5'd13, 5'd10, 5'd0, 1'b1, 32'h0000_0100, 32'h0000_0154, 1'b1);
		add_row(core_pkg::MUL, 5'd14, 5'd5, 5'd5, 1'b0, 32'h0, 32'h0000_0004, 1'b0);
		add_row(core_pkg::SUB, 5'd15, 5'd14, 5'd1, 1'b0, 32'h0, 32'hFFFF_FFFF, 1'b1);
		// back-to-back independent run, no gaps
		add_row(core_pkg::MUL, 5'd16, 5'd3, 5'd2, 1'b0, 32'h0, 32'h0000_0690, 1'b1);
		add_row(core_pkg::ADD, 5'd17, 5'd1, 5'd3, 1'b0, 32'h0, 32'h0000_00F5, 1'b1);
		add_row(core_pkg::MUL, 5'd18, 5'd8, 5'd1, 1'b0, 32'h0, 32'h0000_0190, 1'b1);
		add_row(core_pkg::ADD, 5'd19, 5'd2, 5'd0, 1'b1, 32'h0000_1000, 32'h0000_1007, 1'b1);
		add_row(core_pkg::MUL, 5'd20, 5'd7, 5'd0, 1'b1, 32'h0000_0010, 32'h0000_0F70, 1'b1);
		add_row(core_pkg::ADD, 5'd21, 5'd6, 5'd4, 1'b0, 32'h0, 32'h0000_003C, 1'b1);
		add_row(core_pkg::MUL, 5'd22, 5'd9, 5'd2, 1'b0, 32'h0, 32'h0000_0188, 1'b1);
		add_row(core_pkg::SUB, 5'd23, 5'd0, 5'd0, 1'b1, 32'h0000_0001, 32'hFFFF_FFFF, 1'b1);
		add_row(core_pkg::MUL, 5'd24, 5'd12, 5'd11, 1'b0, 32'h0, 32'h0000_05D0, 1'b1);
		// r0 write still commits its value, reads stay zero
		add_row(core_pkg::ADD, 5'd0, 5'd1, 5'd0, 1'b1, 32'h0000_0022, 32'h0000_0027, 1'b0);
		add_row(core_pkg::ADD, 5'd25, 5'd0, 5'd2, 1'b0, 32'h0, 32'h0000_0007, 1'b0);
		// product keeps the low word only
		add_row(core_pkg::MUL, 5'd26, 5'd5, 5'd0, 1'b1, 32'h0000_0010, 32'hFFFF_FFE0, 1'b0);
	endtask

	////////////////////////////////////////////////
	// commit monitor and timeout
	////////////////////////////////////////////////

	initial begin
		commit_count = 0;
		cycle_count  = 0;
	end

	// commit is registered, so edge sampling sees the cycle's value
	always @(posedge clock) begin
		if (!reset && commit.valid) begin
			if (commit_count >= ROWS) begin
				stop_with_failure("commit seen after every table row had retired");
			end else begin
				compare_reg_idx("commit.dest", commit.dest, row_commit[commit_count].dest);
				compare_commit("commit", commit, row_commit[commit_count]);
				commit_count = commit_count + 1;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			stop_with_failure("timeout, commits stopped before the table retired");
		end
	end

	////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////

	initial begin
		int   row;
		logic accepted;
		logic gap;

		reset      = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		lfsr       = LFSR_SEED;
		row        = 0;
		accepted   = 1'b0;
		build_table();

		repeat (2) @(posedge clock);
		@(negedge clock);
		compare_flag("inst_ready", inst_ready, 1'b1);
		compare_flag("commit.valid", commit.valid, 1'b0);
		reset = 1'b0;

		while (row < ROWS) begin
			@(negedge clock);
			// a request that was not taken stays on the port
			if (!inst_valid || accepted) begin
				gap  = lfsr[0];
				lfsr = lfsr_next(lfsr);
				if (gap && !row_burst[row]) begin
					inst_valid = 1'b0;
				end else begin
					inst_valid = 1'b1;
					inst       = row_inst[row];
				end
			end
			@(posedge clock);
			accepted = inst_valid && inst_ready;
			if (accepted) begin
				row = row + 1;
			end
		end
		@(negedge clock);
		inst_valid = 1'b0;

		wait (commit_count == ROWS);
		// short drain so a stray extra commit gets caught
		repeat (4) @(posedge clock);
		@(negedge clock);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
//////////////////////////////////////////////////
// ooo core slice top level
// issue, exec, reorder buffer and retire wired up
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module ooo_core (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   inst_valid,
	input  wire core_pkg::inst_packet_t inst,
	output logic                        inst_ready,
	output core_pkg::commit_packet_t    commit
);

	////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////

	// issue <-> rob
	core_pkg::alloc_packet_t  alloc;
	core_pkg::rob_tag_t       alloc_tag;
	logic                     rob_full;
	// issue -> exec
	core_pkg::exec_packet_t   exec_op;
	logic                     exec_valid;
	// exec -> rob
	core_pkg::result_packet_t alu_result;
	core_pkg::result_packet_t mul_result;
	// rob -> retire
	core_pkg::commit_packet_t retire;
	// retire <-> issue
	core_pkg::reg_idx_t       src1_idx;
	core_pkg::reg_idx_t       src2_idx;
	core_pkg::xlen_t          rd1;
	core_pkg::xlen_t          rd2;
	logic                     retire_valid;
	core_pkg::reg_idx_t       retire_dest;

	issue_stage issue_stage_i (
		.clock        (clock),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_ready   (inst_ready),
		.rob_full     (rob_full),
		.alloc_tag    (alloc_tag),
		.alloc        (alloc),
		.exec_op      (exec_op),
		.exec_valid   (exec_valid),
		.src1_idx     (src1_idx),
		.src2_idx     (src2_idx),
		.rd1          (rd1),
		.rd2          (rd2),
		.retire_valid (retire_valid),
		.retire_dest  (retire_dest)
	);

	exec_unit exec_unit_i (
		.clock      (clock),
		.reset      (reset),
		.exec_op    (exec_op),
		.exec_valid (exec_valid),
		.alu_result (alu_result),
		.mul_result (mul_result)
	);

	reorder_buffer reorder_buffer_i (
		.clock      (clock),
		.reset      (reset),
		.alloc      (alloc),
		.alloc_tag  (alloc_tag),
		.rob_full   (rob_full),
		.alu_result (alu_result),
		.mul_result (mul_result),
		.retire     (retire)
	);

	retire_unit retire_unit_i (
		.clock        (clock),
		.reset        (reset),
		.retire       (retire),
		.src1_idx     (src1_idx),
		.src2_idx     (src2_idx),
		.rd1          (rd1),
		.rd2          (rd2),
		.retire_valid (retire_valid),
		.retire_dest  (retire_dest),
		.commit       (commit)
	);

endmodule

`default_nettype wire

/* hw/retire_unit.sv */
//////////////////////////////////////////////////
// retire unit
// architectural register file with write-through
// reads, in-order writeback and the commit port
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module retire_unit (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire core_pkg::commit_packet_t retire,
	// read ports for issue
	input  wire core_pkg::reg_idx_t       src1_idx,
	input  wire core_pkg::reg_idx_t       src2_idx,
	output core_pkg::xlen_t               rd1,
	output core_pkg::xlen_t               rd2,
	// scoreboard release
	output logic                          retire_valid,
	output core_pkg::reg_idx_t            retire_dest,
	// registered commit for the outside
	output core_pkg::commit_packet_t      commit
);

	core_pkg::xlen_t regs [`CORE_REG_COUNT];

	// same-cycle write shows through, r0 stays zero
	function automatic core_pkg::xlen_t read_port(input core_pkg::reg_idx_t idx);
		if (retire.valid && retire.dest == idx && idx != '0) begin
			read_port = retire.value;
		end else begin
			read_port = regs[idx];
		end
	endfunction

	always_comb begin
		rd1 = read_port(src1_idx);
		rd2 = read_port(src2_idx);
	end

	// register file, zero after reset
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (retire.valid && retire.dest != '0) begin
			regs[retire.dest] <= retire.value;
		end
	end

	assign retire_valid = retire.valid;
	assign retire_dest  = retire.dest;

	// one-cycle commit strobe after the pop edge
	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= retire.valid;
		end
		commit.dest  <= retire.dest;
		commit.value <= retire.value;
	end

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
//////////////////////////////////////////////////
// reorder buffer
// circular buffer, slots allocated in order,
// completed out of order, released from the head
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module reorder_buffer (
	input  wire logic                     clock,
	input  wire logic                     reset,
	// allocation from issue
	input  wire core_pkg::alloc_packet_t  alloc,
	output core_pkg::rob_tag_t            alloc_tag,
	output logic                          rob_full,
	// results from exec
	input  wire core_pkg::result_packet_t alu_result,
	input  wire core_pkg::result_packet_t mul_result,
	// oldest finished entry to retire
	output core_pkg::commit_packet_t      retire
);

	localparam int DEPTH   = `CORE_ROB_DEPTH;
	localparam int COUNT_W = $clog2(DEPTH) + 1;

	// pointers and occupancy
	core_pkg::rob_tag_t head;
	core_pkg::rob_tag_t tail;
	logic [COUNT_W-1:0] count;

	// slot storage
	core_pkg::reg_idx_t slot_dest  [DEPTH];
	core_pkg::xlen_t    slot_value [DEPTH];
	logic [DEPTH-1:0]   slot_done;

	// slots between head and tail
	logic [DEPTH-1:0] slot_live;

	logic push;
	logic pop;

	assign push = alloc.valid;
	assign pop  = retire.valid;

	assign alloc_tag = tail;
	assign rob_full  = count == COUNT_W'(DEPTH);

	// head goes out whenever it is done
	assign retire.valid = slot_done[head];
	assign retire.dest  = slot_dest[head];
	assign retire.value = slot_value[head];

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			slot_live[i] = {1'b0, core_pkg::rob_tag_t'(i) - head} < count;
		end
	end

	////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) begin
				tail <= tail + 1'b1;
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////
	// slot state
	////////////////////////////////////////////////

	// done bits, cleared on release and set by either port
	always_ff @(posedge clock) begin
		if (reset) begin
			slot_done <= '0;
		end else begin
			if (pop) begin
				slot_done[head] <= 1'b0;
			end
			if (alu_result.valid) begin
				slot_done[alu_result.tag] <= 1'b1;
			end
			if (mul_result.valid) begin
				slot_done[mul_result.tag] <= 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clock) begin
		if (push) begin
			slot_dest[tail] <= alloc.dest;
		end
		if (alu_result.valid) begin
			slot_value[alu_result.tag] <= alu_result.value;
		end
		if (mul_result.valid) begin
			slot_value[mul_result.tag] <= mul_result.value;
		end
	end

	// results only target slots issue has allocated
	a_alu_slot_live: assert property (
		@(posedge clock) disable iff (reset)
		alu_result.valid |-> slot_live[alu_result.tag]
	) else $error("alu result for unallocated slot");

	a_mul_slot_live: assert property (
		@(posedge clock) disable iff (reset)
		mul_result.valid |-> slot_live[mul_result.tag]
	) else $error("mul result for unallocated slot");

	a_count_bound: assert property (
		@(posedge clock) disable iff (reset)
		count <= COUNT_W'(DEPTH)
	) else $error("rob count past depth");

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
//////////////////////////////////////////////////
// exec unit
// single-cycle alu path and a multiply pipeline,
// both report results tagged with the rob slot
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module exec_unit (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire core_pkg::exec_packet_t exec_op,
	input  wire logic                   exec_valid,
	output core_pkg::result_packet_t    alu_result,
	output core_pkg::result_packet_t    mul_result
);

	localparam int MUL_STAGES = `CORE_MUL_STAGES;
	// shift amount width, 5 bits for 32-bit words
	localparam int SHAMT_W = $clog2(`CORE_XLEN);

	logic            is_mul;
	logic            is_alu;
	core_pkg::xlen_t alu_value;

	// multiply pipeline, product formed on entry
	logic [MUL_STAGES-1:0] mul_valid;
	core_pkg::rob_tag_t    mul_tag  [MUL_STAGES];
	core_pkg::xlen_t       mul_prod [MUL_STAGES];

	assign is_mul = exec_valid && exec_op.func == core_pkg::MUL;
	assign is_alu = exec_valid && exec_op.func != core_pkg::MUL;

	////////////////////////////////////////////////
	// alu path
	////////////////////////////////////////////////

	always_comb begin
		case (exec_op.func)
			core_pkg::ADD: alu_value = exec_op.op_a + exec_op.op_b;
			// wraps modulo 2^xlen
			core_pkg::SUB: alu_value = exec_op.op_a - exec_op.op_b;
			core_pkg::AND: alu_value = exec_op.op_a & exec_op.op_b;
			core_pkg::XOR: alu_value = exec_op.op_a ^ exec_op.op_b;
			core_pkg::SLL: alu_value = exec_op.op_a << exec_op.op_b[SHAMT_W-1:0];
			default:       alu_value = '0;
		endcase
	end

	// result lands in the rob one edge later
	always_ff @(posedge clock) begin
		if (reset) begin
			alu_result.valid <= 1'b0;
		end else begin
			alu_result.valid <= is_alu;
		end
		alu_result.tag   <= exec_op.tag;
		alu_result.value <= alu_value;
	end

	////////////////////////////////////////////////
	// multiply pipeline
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			mul_valid <= '0;
		end else begin
			mul_valid <= {mul_valid[MUL_STAGES-2:0], is_mul};
		end
	end

	// tag and low product word ride along
	always_ff @(posedge clock) begin
		mul_tag[0]  <= exec_op.tag;
		mul_prod[0] <= exec_op.op_a * exec_op.op_b;
		for (int i = 1; i < MUL_STAGES; i++) begin
			mul_tag[i]  <= mul_tag[i-1];
			mul_prod[i] <= mul_prod[i-1];
		end
	end

	assign mul_result.valid = mul_valid[MUL_STAGES-1];
	assign mul_result.tag   = mul_tag[MUL_STAGES-1];
	assign mul_result.value = mul_prod[MUL_STAGES-1];

	// distinct slots in flight, so ports never collide
	a_result_tags_differ: assert property (
		@(posedge clock) disable iff (reset)
		(alu_result.valid && mul_result.valid) |-> alu_result.tag != mul_result.tag
	) else $error("alu and mul results share a tag");

endmodule

`default_nettype wire

/* hw/issue_stage.sv */
//////////////////////////////////////////////////
// issue stage
// one-entry holding register with a scoreboard of
// pending destinations; reads operands, allocates
// a rob slot and dispatches to the exec unit
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

`include "core_config.svh"

module issue_stage (
	input  wire logic                   clock,
	input  wire logic                   reset,
	// instruction input
	input  wire logic                   inst_valid,
	input  wire core_pkg::inst_packet_t inst,
	output logic                        inst_ready,
	// rob allocation
	input  wire logic                   rob_full,
	input  wire core_pkg::rob_tag_t     alloc_tag,
	output core_pkg::alloc_packet_t     alloc,
	// exec unit
	output core_pkg::exec_packet_t      exec_op,
	output logic                        exec_valid,
	// register file read ports
	output core_pkg::reg_idx_t          src1_idx,
	output core_pkg::reg_idx_t          src2_idx,
	input  wire core_pkg::xlen_t        rd1,
	input  wire core_pkg::xlen_t        rd2,
	// scoreboard release from retire
	input  wire logic                   retire_valid,
	input  wire core_pkg::reg_idx_t     retire_dest
);

	// holding register
	logic                   hold_valid;
	core_pkg::inst_packet_t hold_inst;

	// one pending bit per architectural register
	logic [`CORE_REG_COUNT-1:0] pending;

	logic src1_busy;
	logic src2_busy;
	logic dest_busy;
	logic dispatch;

	// a register retiring this cycle counts as free,
	// the read port already returns the new value
	function automatic logic reg_busy(input core_pkg::reg_idx_t r);
		reg_busy = pending[r] && !(retire_valid && retire_dest == r);
	endfunction

	always_comb begin
		src1_busy = reg_busy(hold_inst.src1);
		src2_busy = !hold_inst.use_imm && reg_busy(hold_inst.src2);
		// waw stall so one pending bit per register is enough
		dest_busy = reg_busy(hold_inst.dest);
	end

	assign dispatch   = hold_valid && !rob_full && !src1_busy && !src2_busy && !dest_busy;
	assign inst_ready = !hold_valid || dispatch;

	// operand reads straight from the held instruction
	assign src1_idx = hold_inst.src1;
	assign src2_idx = hold_inst.src2;

	// allocation and dispatch happen together
	assign alloc.valid = dispatch;
	assign alloc.dest  = hold_inst.dest;

	assign exec_valid   = dispatch;
	assign exec_op.func = hold_inst.func;
	assign exec_op.tag  = alloc_tag;
	assign exec_op.op_a = rd1;
	assign exec_op.op_b = hold_inst.use_imm ? hold_inst.imm : rd2;

	////////////////////////////////////////////////
	// holding register
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_valid <= 1'b0;
		end else if (inst_valid && inst_ready) begin
			hold_valid <= 1'b1;
		end else if (dispatch) begin
			hold_valid <= 1'b0;
		end
	end

	// payload only loads on a transfer
	always_ff @(posedge clock) begin
		if (inst_valid && inst_ready) begin
			hold_inst <= inst;
		end
	end

	////////////////////////////////////////////////
	// scoreboard
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= '0;
		end else begin
			if (retire_valid) begin
				pending[retire_dest] <= 1'b0;
			end
			// set wins over a same-edge retire, r0 never pending
			if (dispatch && hold_inst.dest != '0) begin
				pending[hold_inst.dest] <= 1'b1;
			end
		end
	end

	// every retiring destination was marked at dispatch
	a_retire_was_pending: assert property (
		@(posedge clock) disable iff (reset)
		(retire_valid && retire_dest != '0) |-> pending[retire_dest]
	) else $error("retire of a register not marked pending");

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
//////////////////////////////////////////////////
// core slice package
// width typedefs, ALU operation encoding and the
// packets passed between issue, exec, ROB, retire
//////////////////////////////////////////////////

`default_nettype none

`include "core_config.svh"

package core_pkg;

	////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////

	// one data word
	typedef logic [`CORE_XLEN-1:0] xlen_t;
	// architectural register index
	typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;
	// reorder buffer slot
	typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] rob_tag_t;

	// alu operations
	// SLL shifts by the low bits of operand b only
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		XOR,
		SLL,
		MUL
	} alu_func_e;

	////////////////////////////////////////////////
	// packets
	////////////////////////////////////////////////

	// decoded instruction from outside
	// use_imm selects imm as operand b, src2 unused then
	typedef struct packed {
		alu_func_e func;
		reg_idx_t  dest;
		reg_idx_t  src1;
		reg_idx_t  src2;
		logic      use_imm;
		xlen_t     imm;
	} inst_packet_t;

	// operation handed to the exec unit
	typedef struct packed {
		alu_func_e func;
		rob_tag_t  tag;
		xlen_t     op_a;
		xlen_t     op_b;
	} exec_packet_t;

	// finished value back to its rob slot
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		xlen_t    value;
	} result_packet_t;

	// slot request from issue
	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
	} alloc_packet_t;

	// in-order retirement, also the commit port
	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		xlen_t    value;
	} commit_packet_t;

endpackage

`default_nettype wire

/* hw/core_config.svh */
//////////////////////////////////////////////////
// core slice configuration
// sizes shared by the package and the RTL blocks
//////////////////////////////////////////////////

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path width in bits
`define CORE_XLEN 32

// architectural registers, r0 hardwired to zero
`define CORE_REG_COUNT 32

// reorder buffer slots
// power of two only, tag arithmetic wraps
`define CORE_ROB_DEPTH 8

// multiply latency from dispatch to result, in cycles
`define CORE_MUL_STAGES 4

`endif
